// File: sources.f
hw/vmpeg_pkg.sv
hw/bus_decode.sv
hw/dclk_timer.sv
hw/command_exec.sv
hw/irq_status.sv
hw/read_mux.sv
hw/vmpeg_host.sv
testbench/vmpeg_host_assert.sv
testbench/tb_vmpeg_host.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps \
        -f sources.f --top-module tb_vmpeg_host -Mdir obj_dir \
    && ./obj_dir/Vtb_vmpeg_host \
    || exit 1

// File: testbench/tb_vmpeg_host.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vmpeg_host;
    import vmpeg_pkg::*;

    logic        clk;
    logic        reset;
    logic        cs;
    logic        uds;
    logic        lds;
    logic        write_strobe;
    logic [23:1] address;
    reg_data_t   din;
    logic        intack;
    logic        ack;
    logic        done_in;
    logic        vsync;
    fma_events_t fma_events;
    fmv_events_t fmv_events;
    reg_data_t   dout;
    logic        bus_ack;
    logic        intreq;
    logic        req;
    logic        rdy;
    logic        fmv_dsp_enable;
    logic        fmv_playback_active;
    logic        fifo_reset;
    stream_t     fma_stream;
    stream_t     fmv_stream;
    logic        dma_for_fma;
    logic        mpeg_ram_enabled;

    logic [31:0] rng;
    int          write_count;
    reg_data_t   fma_ivec_v, fmv_ivec_v, fma_ier_v, fmv_ier_v;
    reg_data_t   exp_stat;
    logic        exp_dsp, exp_play;

    vmpeg_host #(.DCLK_DIVIDER(4)) dut (
        .clk, .reset, .cs, .uds, .lds, .write_strobe, .address, .din,
        .intack, .ack, .done_in, .vsync, .fma_events, .fmv_events,
        .dout, .bus_ack, .intreq, .req, .rdy, .fmv_dsp_enable,
        .fmv_playback_active, .fifo_reset, .fma_stream, .fmv_stream,
        .dma_for_fma, .mpeg_ram_enabled
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_word(output reg_data_t w);
        rng = xorshift32(rng);
        w   = rng[15:0];
    endtask

    task automatic check_word(input string name, input reg_data_t got, input reg_data_t expected);
        assert (got === expected) else begin
            $display("[ERROR] %s got %h expected %h", name, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        assert (got === expected) else begin
            $display("[ERROR] %s got %h expected %h", name, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // Hold the access until acknowledged, then release after the ack cycle
    task automatic bus_access(input logic wr, input reg_addr_t waddr, input reg_data_t wdata,
                              output reg_data_t rdata);
        int n;
        @(posedge clk);
        #1;
        cs           = 1'b1;
        uds          = 1'b1;
        lds          = 1'b1;
        write_strobe = wr;
        address      = {8'h00, waddr};
        din          = wdata;
        n = 0;
        do begin
            if (n == 20) report_timeout("bus_ack");
            @(posedge clk);
            #1;
            n++;
        end while (!bus_ack);
        rdata = dout;
        @(posedge clk);
        #1;
        cs           = 1'b0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
    endtask

    task automatic bus_write(input reg_addr_t waddr, input reg_data_t wdata);
        reg_data_t unused;
        bus_access(1'b1, waddr, wdata, unused);
        write_count++;
    endtask

    task automatic bus_read(input reg_addr_t waddr, output reg_data_t rdata);
        bus_access(1'b0, waddr, 16'h0000, rdata);
    endtask

    task automatic read_check(input string name, input reg_addr_t waddr, input reg_data_t expected);
        reg_data_t value;
        bus_read(waddr, value);
        check_word(name, value, expected);
    endtask

    task automatic stop_timer();
        bus_write(ADDR_FMV_TCNT, 16'hffff);   // Period far beyond the run
        bus_write(ADDR_FMV_TRLD, 16'h0000);
    endtask

    task automatic pulse_done();
        @(posedge clk);
        #1;
        done_in = 1'b1;
        ack     = 1'b1;
        @(posedge clk);
        #1;
        done_in = 1'b0;
        ack     = 1'b0;
    endtask

    // Expected decoder state follows the SYSCMD bit rules
    task automatic apply_syscmd(input reg_data_t cmd_word);
        bus_write(ADDR_FMV_SYSCMD, cmd_word);
        if (cmd_word[SYS_PLAY]) exp_play = 1'b1;
        if (cmd_word[SYS_PAUSE]) exp_play = 1'b0;
        if (cmd_word[SYS_CLEAR] || cmd_word[SYS_DEC_OFF]) begin
            exp_dsp  = 1'b0;
            exp_play = 1'b0;
        end
        if (cmd_word[SYS_DEC_ON]) exp_dsp = 1'b1;
        check_bit("fmv_dsp_enable", fmv_dsp_enable, exp_dsp);
        check_bit("fmv_playback_active", fmv_playback_active, exp_play);
    endtask

    function automatic int fma_bit(input int i);
        case (i)
            0: return FMA_EOI;
            1: return FMA_UNF;
            2: return FMA_UPD;
            default: return FMA_DEC;
        endcase
    endfunction

    // Event index to FMV flag position
    function automatic int fmv_bit(input int i);
        case (i)
            0: return 5;    // ndat
            1: return 9;    // esi
            2: return 10;   // eii
            3: return 3;    // eod
            4: return 2;    // pic
            5: return 1;    // gop
            default: return 0;
        endcase
    endfunction

    initial begin
        reg_data_t w, h1, l1, h2, l2;
        int n;
        rng = 32'he5c5662b;
        write_count = 0;
        reset = 1'b1;
        cs = 1'b0;
        uds = 1'b0;
        lds = 1'b0;
        write_strobe = 1'b0;
        address = '0;
        din = '0;
        intack = 1'b0;
        ack = 1'b0;
        done_in = 1'b0;
        vsync = 1'b0;
        fma_events = '0;
        fmv_events = '0;
        exp_stat = '0;
        exp_dsp = 1'b0;
        exp_play = 1'b0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        stop_timer();

        // Register write and read back
        next_word(fma_ier_v);
        bus_write(ADDR_FMA_IER, fma_ier_v);
        read_check("fma_ier", ADDR_FMA_IER, fma_ier_v);
        next_word(fmv_ier_v);
        bus_write(ADDR_FMV_IER, fmv_ier_v);
        read_check("fmv_ier", ADDR_FMV_IER, fmv_ier_v);
        next_word(fma_ivec_v);
        bus_write(ADDR_FMA_IVEC, fma_ivec_v);
        read_check("fma_ivec", ADDR_FMA_IVEC, fma_ivec_v);
        next_word(fmv_ivec_v);
        bus_write(ADDR_FMV_IVEC, fmv_ivec_v);
        read_check("fmv_ivec", ADDR_FMV_IVEC, fmv_ivec_v);
        next_word(w);
        bus_write(ADDR_FMV_TCNT, w);
        read_check("tcnt", ADDR_FMV_TCNT, w);
        next_word(w);
        bus_write(ADDR_FMA_STRM, w);
        read_check("fma_strm", ADDR_FMA_STRM, {12'd0, w[3:0]});
        check_word("fma_stream", {12'd0, fma_stream}, {12'd0, w[3:0]});
        next_word(w);
        bus_write(ADDR_FMV_STRM, w);
        read_check("fmv_strm", ADDR_FMV_STRM, {12'd0, w[3:0]});
        check_word("fmv_stream", {12'd0, fmv_stream}, {12'd0, w[3:0]});
        stop_timer();
        bus_read(ADDR_FMA_ISR, w);   // Drop any tick from the random TCNT
        bus_read(ADDR_FMV_ISR, w);

        // Event strobes, status and clear on read
        fma_ier_v = 16'h0018;   // DEC and UNF
        fmv_ier_v = 16'h0825;   // vsync, ndat, pic, seq
        bus_write(ADDR_FMA_IER, fma_ier_v);
        bus_write(ADDR_FMV_IER, fmv_ier_v);
        for (int i = 3; i >= 0; i--) begin
            @(posedge clk);
            #1 fma_events = 4'b0001 << i;
            @(posedge clk);
            #1 fma_events = '0;
            if (i == 2) exp_stat[FMA_DEC] = 1'b0;
            exp_stat[fma_bit(i)] = 1'b1;
            check_bit("intreq", intreq, fma_ier_v[fma_bit(i)]);
            read_check("fma_stat", ADDR_FMA_STAT, exp_stat);
            read_check("fma_isr", ADDR_FMA_ISR, 16'd1 << fma_bit(i));
            read_check("fma_isr", ADDR_FMA_ISR, 16'h0000);
        end
        for (int i = 0; i < 7; i++) begin
            @(posedge clk);
            #1 fmv_events = 7'b0000001 << i;
            @(posedge clk);
            #1 fmv_events = '0;
            check_bit("intreq", intreq, fmv_ier_v[fmv_bit(i)]);
            read_check("fmv_isr", ADDR_FMV_ISR, 16'd1 << fmv_bit(i));
            read_check("fmv_isr", ADDR_FMV_ISR, 16'h0000);
        end
        @(posedge clk);
        #1 vsync = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        check_bit("intreq", intreq, 1'b1);
        read_check("fmv_isr", ADDR_FMV_ISR, 16'h0800);
        vsync = 1'b0;

        // Interrupt vector with FMA ahead of FMV
        bus_write(ADDR_FMA_IER, 16'h0010);
        bus_write(ADDR_FMV_IER, 16'h0001);
        @(posedge clk);
        #1;
        fma_events = 4'b1000;
        fmv_events = 7'b1000000;
        @(posedge clk);
        #1;
        fma_events = '0;
        fmv_events = '0;
        intack = 1'b1;
        #2 check_word("dout", dout, {fma_ivec_v[7:0], fma_ivec_v[7:0]});
        intack = 1'b0;
        bus_read(ADDR_FMA_ISR, w);
        intack = 1'b1;
        #2 check_word("dout", dout, {fmv_ivec_v[10:3], fmv_ivec_v[10:3]});
        intack = 1'b0;
        bus_read(ADDR_FMV_ISR, w);

        // Periodic timer and DCLK
        bus_write(ADDR_FMA_IER, 16'h0100);
        bus_write(ADDR_FMV_IER, 16'h0100);
        bus_write(ADDR_FMV_TCNT, 16'd2);
        bus_write(ADDR_FMV_TRLD, 16'h0000);
        n = 0;
        while (!intreq) begin
            if (n == 2000) report_timeout("timer intreq");
            @(posedge clk);
            #1;
            n++;
        end
        read_check("fmv_isr", ADDR_FMV_ISR, 16'h0100);
        read_check("fma_isr", ADDR_FMA_ISR, 16'h0100);
        check_bit("intreq", intreq, 1'b0);
        stop_timer();
        bus_write(ADDR_FMA_IER, 16'h0000);
        bus_write(ADDR_FMV_IER, 16'h0000);
        bus_read(ADDR_DCLKH, h1);
        bus_read(ADDR_DCLKL, l1);
        repeat (20) @(posedge clk);
        read_check("dclkl", ADDR_DCLKL, l1);   // Low word stays frozen until the next DCLKH read
        bus_read(ADDR_DCLKH, h2);
        bus_read(ADDR_DCLKL, l2);
        assert ({h2, l2} > {h1, l1}) else begin
            $display("[ERROR] dclk got %h not above %h", {h2, l2}, {h1, l1});
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end

        // Decoder controls, DMA and FIFO reset
        apply_syscmd(16'h1000);
        apply_syscmd(16'h0008);
        apply_syscmd(16'h0010);
        apply_syscmd(16'h0008);
        apply_syscmd(16'h2000);
        apply_syscmd(16'h3000);   // On wins over off
        apply_syscmd(16'h0100);
        bus_write(ADDR_FMA_CMD, 16'h8000);
        check_bit("req", req, 1'b1);
        check_bit("rdy", rdy, 1'b1);
        check_bit("dma_for_fma", dma_for_fma, 1'b1);
        pulse_done();
        check_bit("req", req, 1'b0);
        read_check("fma_cmd", ADDR_FMA_CMD, 16'h0000);
        apply_syscmd(16'h8000);
        check_bit("req", req, 1'b1);
        check_bit("dma_for_fma", dma_for_fma, 1'b0);
        pulse_done();
        check_bit("req", req, 1'b0);
        bus_write(ADDR_FMA_CMD, 16'h0001);
        check_bit("fifo_reset", fifo_reset, 1'b0);
        bus_write(ADDR_FMA_CMD, 16'h0002);
        check_bit("fifo_reset", fifo_reset, 1'b1);
        @(posedge clk);
        #1 check_bit("fifo_reset", fifo_reset, 1'b0);

        // RAM enable after 64 writes
        while (write_count < 63) bus_write(ADDR_FMA_STRM, 16'h0000);
        check_bit("mpeg_ram_enabled", mpeg_ram_enabled, 1'b0);
        bus_write(ADDR_FMA_STRM, 16'h0000);
        check_bit("mpeg_ram_enabled", mpeg_ram_enabled, 1'b1);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/vmpeg_host_assert.sv
`timescale 1ns/1ps
`default_nettype none

module vmpeg_host_assert (
    input logic clk,
    input logic reset,
    input logic bus_ack,
    input logic intreq,
    input logic req,
    input logic rdy,
    input logic mpeg_ram_enabled,
    input logic fifo_reset
);

    // Ack toggles, so it is never high twice in a row
    ack_toggles: assert property (@(posedge clk) disable iff (reset) bus_ack |=> !bus_ack)
        else $error("bus_ack held high for two cycles");

    dma_lines_match: assert property (@(posedge clk) disable iff (reset) req == rdy)
        else $error("req and rdy differ");

    outputs_idle_after_reset: assert property (
        @(posedge clk) reset |=> (!bus_ack && !intreq && !req && !mpeg_ram_enabled && !fifo_reset)
    ) else $error("output active in the cycle after reset");

endmodule

bind vmpeg_host vmpeg_host_assert u_vmpeg_host_assert (
    .clk(clk),
    .reset(reset),
    .bus_ack(bus_ack),
    .intreq(intreq),
    .req(req),
    .rdy(rdy),
    .mpeg_ram_enabled(mpeg_ram_enabled),
    .fifo_reset(fifo_reset)
);

`default_nettype wire

// File: hw/vmpeg_host.sv
`timescale 1ns/1ps
`default_nettype none

module vmpeg_host #(
    parameter int DCLK_DIVIDER = vmpeg_pkg::DEFAULT_DCLK_DIVIDER
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cs,
    input  logic                   uds,
    input  logic                   lds,
    input  logic                   write_strobe,
    input  logic [23:1]            address,
    input  vmpeg_pkg::reg_data_t   din,
    input  logic                   intack,
    input  logic                   ack,
    input  logic                   done_in,
    input  logic                   vsync,
    input  vmpeg_pkg::fma_events_t fma_events,
    input  vmpeg_pkg::fmv_events_t fmv_events,
    output vmpeg_pkg::reg_data_t   dout,
    output logic                   bus_ack,
    output logic                   intreq,
    output logic                   req,
    output logic                   rdy,
    output logic                   fmv_dsp_enable,
    output logic                   fmv_playback_active,
    output logic                   fifo_reset,
    output vmpeg_pkg::stream_t     fma_stream,
    output vmpeg_pkg::stream_t     fmv_stream,
    output logic                   dma_for_fma,
    output logic                   mpeg_ram_enabled
);
    import vmpeg_pkg::*;

    bus_cmd_t   cmd;
    reg_data_t  fma_cmd, fma_ier, fma_ivec, fmv_ivec, tcnt;
    reg_data_t  fma_stat, fma_isr, dclkl_latch;
    fmv_flags_t fmv_ier, fmv_isr;
    dclk_t      dclk;
    logic       timer_tick, dma_active, fma_intreq, fmv_intreq;

    bus_decode u_bus_decode (
        .clk, .reset, .cs, .uds, .lds, .write_strobe, .address, .din,
        .bus_ack, .cmd, .mpeg_ram_enabled
    );

    dclk_timer #(.DCLK_DIVIDER(DCLK_DIVIDER)) u_dclk_timer (
        .clk, .reset, .cmd, .tcnt, .dclk, .dclkl_latch, .timer_tick
    );

    command_exec u_command_exec (
        .clk, .reset, .cmd, .ack, .done_in,
        .fma_cmd, .fma_ier, .fma_ivec, .fmv_ivec, .tcnt, .fmv_ier,
        .fma_stream, .fmv_stream, .dma_active, .dma_for_fma,
        .fmv_dsp_enable, .fmv_playback_active, .fifo_reset
    );

    irq_status u_irq_status (
        .clk, .reset, .vsync, .timer_tick, .fma_events, .fmv_events, .cmd,
        .fma_ier, .fmv_ier, .fma_stat, .fma_isr, .fmv_isr, .fma_intreq, .fmv_intreq
    );

    read_mux u_read_mux (
        .cmd_addr(cmd.addr), .intack,
        .fma_cmd, .fma_stat, .fma_ivec, .fma_isr, .fma_ier, .fma_stream,
        .dclk, .dclkl_latch, .fmv_ier, .fmv_isr, .tcnt, .fmv_stream, .fmv_ivec,
        .fma_intreq, .dout
    );

    assign intreq = fma_intreq || fmv_intreq;
    assign req    = dma_active;   // Host DMA sees both lines together
    assign rdy    = dma_active;

endmodule

`default_nettype wire

// File: hw/read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module read_mux (
    input  vmpeg_pkg::reg_addr_t  cmd_addr,
    input  logic                  intack,
    input  vmpeg_pkg::reg_data_t  fma_cmd,
    input  vmpeg_pkg::reg_data_t  fma_stat,
    input  vmpeg_pkg::reg_data_t  fma_ivec,
    input  vmpeg_pkg::reg_data_t  fma_isr,
    input  vmpeg_pkg::reg_data_t  fma_ier,
    input  vmpeg_pkg::stream_t    fma_stream,
    input  vmpeg_pkg::dclk_t      dclk,
    input  vmpeg_pkg::reg_data_t  dclkl_latch,
    input  vmpeg_pkg::fmv_flags_t fmv_ier,
    input  vmpeg_pkg::fmv_flags_t fmv_isr,
    input  vmpeg_pkg::reg_data_t  tcnt,
    input  vmpeg_pkg::stream_t    fmv_stream,
    input  vmpeg_pkg::reg_data_t  fmv_ivec,
    input  logic                  fma_intreq,
    output vmpeg_pkg::reg_data_t  dout
);
    import vmpeg_pkg::*;

    always_comb begin
        case (cmd_addr)
            ADDR_FMA_CMD:  dout = fma_cmd;
            ADDR_FMA_STAT: dout = fma_stat;
            ADDR_FMA_STRM: dout = {12'd0, fma_stream};
            ADDR_FMA_IVEC: dout = fma_ivec;
            ADDR_DCLKH:    dout = dclk[31:16];
            ADDR_DCLKL:    dout = dclkl_latch;   // Snapshot from the DCLKH read
            ADDR_FMA_ISR:  dout = fma_isr;
            ADDR_FMA_IER:  dout = fma_ier;
            ADDR_FMV_IER:  dout = fmv_ier;
            ADDR_FMV_ISR:  dout = fmv_isr;
            ADDR_FMV_TCNT: dout = tcnt;
            ADDR_FMV_STRM: dout = {12'd0, fmv_stream};
            ADDR_FMV_IVEC: dout = fmv_ivec;
            default:       dout = '0;
        endcase

        // Vector byte on both halves, FMA first
        if (intack) begin
            if (fma_intreq) dout = {fma_ivec[7:0], fma_ivec[7:0]};
            else dout = {fmv_ivec[10:3], fmv_ivec[10:3]};
        end
    end

endmodule

`default_nettype wire

// File: hw/irq_status.sv
`timescale 1ns/1ps
`default_nettype none

module irq_status (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   vsync,
    input  logic                   timer_tick,
    input  vmpeg_pkg::fma_events_t fma_events,
    input  vmpeg_pkg::fmv_events_t fmv_events,
    input  vmpeg_pkg::bus_cmd_t    cmd,
    input  vmpeg_pkg::reg_data_t   fma_ier,
    input  vmpeg_pkg::fmv_flags_t  fmv_ier,
    output vmpeg_pkg::reg_data_t   fma_stat,
    output vmpeg_pkg::reg_data_t   fma_isr,
    output vmpeg_pkg::fmv_flags_t  fmv_isr,
    output logic                   fma_intreq,
    output logic                   fmv_intreq
);
    import vmpeg_pkg::*;

    logic vsync_s;   // vsync comes from the video clock domain
    logic vsync_q;

    always_ff @(posedge clk) begin
        vsync_s <= vsync;
        vsync_q <= vsync_s;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fma_stat <= '0;
            fma_isr  <= '0;
            fmv_isr  <= '0;
        end else begin
            // Clear on read first, so a set on the same edge survives
            if (cmd.rd && cmd.addr == ADDR_FMA_ISR) fma_isr <= '0;
            if (cmd.rd && cmd.addr == ADDR_FMV_ISR) fmv_isr <= '0;

            if (fma_events.decoding_started) begin
                fma_stat[FMA_DEC] <= 1'b1;
                fma_isr[FMA_DEC]  <= 1'b1;
            end
            if (fma_events.frame_decoded) begin
                fma_stat[FMA_DEC] <= 1'b0;   // First frame is out
                fma_stat[FMA_UPD] <= 1'b1;
                fma_isr[FMA_UPD]  <= 1'b1;
            end
            if (fma_events.underflow) begin
                fma_stat[FMA_UNF] <= 1'b1;
                fma_isr[FMA_UNF]  <= 1'b1;
            end
            if (fma_events.program_end) begin
                fma_stat[FMA_EOI] <= 1'b1;
                fma_isr[FMA_EOI]  <= 1'b1;
            end

            if (fmv_events.seq_header) fmv_isr.seq <= 1'b1;
            if (fmv_events.gop) fmv_isr.gop <= 1'b1;
            if (fmv_events.picture) fmv_isr.pic <= 1'b1;
            if (fmv_events.last_picture) fmv_isr.eod <= 1'b1;
            if (fmv_events.program_end) fmv_isr.eii <= 1'b1;
            if (fmv_events.seq_end) fmv_isr.esi <= 1'b1;
            if (fmv_events.underflow) fmv_isr.ndat <= 1'b1;
            if (vsync_s && !vsync_q) fmv_isr.vsync <= 1'b1;

            // Periodic timer also polls the audio unit
            if (timer_tick) begin
                fmv_isr.tim       <= 1'b1;
                fma_isr[FMA_POLL] <= 1'b1;
            end
        end
    end

    assign fma_intreq = |(fma_isr & fma_ier);
    assign fmv_intreq = |(reg_data_t'(fmv_isr) & reg_data_t'(fmv_ier));

endmodule

`default_nettype wire

// File: hw/command_exec.sv
`timescale 1ns/1ps
`default_nettype none

module command_exec (
    input  logic                  clk,
    input  logic                  reset,
    input  vmpeg_pkg::bus_cmd_t   cmd,
    input  logic                  ack,
    input  logic                  done_in,
    output vmpeg_pkg::reg_data_t  fma_cmd,
    output vmpeg_pkg::reg_data_t  fma_ier,
    output vmpeg_pkg::reg_data_t  fma_ivec,
    output vmpeg_pkg::reg_data_t  fmv_ivec,
    output vmpeg_pkg::reg_data_t  tcnt,
    output vmpeg_pkg::fmv_flags_t fmv_ier,
    output vmpeg_pkg::stream_t    fma_stream,
    output vmpeg_pkg::stream_t    fmv_stream,
    output logic                  dma_active,
    output logic                  dma_for_fma,
    output logic                  fmv_dsp_enable,
    output logic                  fmv_playback_active,
    output logic                  fifo_reset
);
    import vmpeg_pkg::*;

    reg_data_t wdata;

    assign wdata = cmd.data;

    always_ff @(posedge clk) begin
        if (reset) begin
            fma_cmd             <= '0;
            fma_ier             <= '0;
            fma_ivec            <= '0;
            fmv_ivec            <= '0;
            tcnt                <= DEFAULT_TCNT;
            fmv_ier             <= '0;
            fma_stream          <= '0;
            fmv_stream          <= '0;
            dma_active          <= 1'b0;
            dma_for_fma         <= 1'b0;
            fmv_dsp_enable      <= 1'b0;
            fmv_playback_active <= 1'b0;
            fifo_reset          <= 1'b0;
        end else begin
            fifo_reset <= 1'b0;

            // End of transfer, a new start in the same cycle wins
            if (done_in && ack) begin
                dma_active       <= 1'b0;
                fma_cmd[CMD_DMA] <= 1'b0;
            end

            if (cmd.wr) begin
                case (cmd.addr)
                    ADDR_FMA_CMD: begin
                        fma_cmd <= wdata;
                        if (wdata[CMD_DMA]) begin
                            dma_active  <= 1'b1;
                            dma_for_fma <= 1'b1;
                        end
                        // Start after stop flushes the audio input
                        if (wdata == 16'd2 && fma_cmd == 16'd1) begin
                            fifo_reset <= 1'b1;
                        end
                    end
                    ADDR_FMA_STRM: fma_stream <= wdata[3:0];
                    ADDR_FMA_IVEC: fma_ivec <= wdata;
                    ADDR_FMA_IER:  fma_ier <= wdata;
                    ADDR_FMV_IER:  fmv_ier <= wdata;
                    ADDR_FMV_TCNT: tcnt <= wdata;
                    ADDR_FMV_STRM: fmv_stream <= wdata[3:0];
                    ADDR_FMV_IVEC: fmv_ivec <= wdata;
                    ADDR_FMV_SYSCMD: begin
                        if (wdata[SYS_DMA]) begin
                            dma_active  <= 1'b1;
                            dma_for_fma <= 1'b0;
                        end
                        if (wdata[SYS_PLAY]) fmv_playback_active <= 1'b1;
                        if (wdata[SYS_PAUSE]) fmv_playback_active <= 1'b0;
                        if (wdata[SYS_CLEAR] || wdata[SYS_DEC_OFF]) begin
                            fmv_dsp_enable      <= 1'b0;
                            fmv_playback_active <= 1'b0;
                        end
                        if (wdata[SYS_DEC_ON]) fmv_dsp_enable <= 1'b1;   // Last, so it wins
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/dclk_timer.sv
`timescale 1ns/1ps
`default_nettype none

module dclk_timer #(
    parameter int DCLK_DIVIDER = vmpeg_pkg::DEFAULT_DCLK_DIVIDER
) (
    input  logic                 clk,
    input  logic                 reset,
    input  vmpeg_pkg::bus_cmd_t  cmd,
    input  vmpeg_pkg::reg_data_t tcnt,
    output vmpeg_pkg::dclk_t     dclk,
    output vmpeg_pkg::reg_data_t dclkl_latch,
    output logic                 timer_tick
);
    import vmpeg_pkg::*;

    localparam int DIV_W = (DCLK_DIVIDER > 1) ? $clog2(DCLK_DIVIDER) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             dclk_tick;
    logic [18:0]      timer_cnt;   // Low 3 bits count DCLK ticks within one unit

    assign dclk_tick = (div_cnt == DIV_W'(DCLK_DIVIDER - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            dclk    <= '0;
        end else if (dclk_tick) begin
            div_cnt <= '0;
            dclk    <= dclk + 32'd1;
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    // Reading the high word freezes the low word for the following read
    always_ff @(posedge clk) begin
        if (cmd.rd && cmd.addr == ADDR_DCLKH) begin
            dclkl_latch <= dclk[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt  <= '0;
            timer_tick <= 1'b0;
        end else begin
            timer_tick <= 1'b0;
            if (cmd.wr && cmd.addr == ADDR_FMV_TRLD) begin
                timer_cnt <= '0;   // Reload restarts the period
            end else if (dclk_tick) begin
                if (timer_cnt[18:3] == tcnt) begin
                    timer_tick <= 1'b1;
                    timer_cnt  <= '0;
                end else begin
                    timer_cnt <= timer_cnt + 19'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cs,
    input  logic                 uds,
    input  logic                 lds,
    input  logic                 write_strobe,
    input  logic [23:1]          address,
    input  vmpeg_pkg::reg_data_t din,
    output logic                 bus_ack,
    output vmpeg_pkg::bus_cmd_t  cmd,
    output logic                 mpeg_ram_enabled
);
    logic       access;
    logic       ack_cycle;
    logic [5:0] write_cnt;

    assign access    = cs && (uds || lds);
    assign ack_cycle = access && bus_ack;

    // Ack toggles for as long as the CPU holds the access
    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack <= 1'b0;
        end else if (access) begin
            bus_ack <= !bus_ack;
        end else begin
            bus_ack <= 1'b0;
        end
    end

    always_comb begin
        cmd.rd   = ack_cycle && !write_strobe;
        cmd.wr   = ack_cycle && write_strobe;
        cmd.addr = address[15:1];   // Also drives the read mux during the access
        cmd.data = din;
    end

    // The OS RAM probe stops seeing MPEG RAM once the driver has written enough
    always_ff @(posedge clk) begin
        if (reset) begin
            write_cnt        <= '0;
            mpeg_ram_enabled <= 1'b0;
        end else if (cmd.wr) begin
            write_cnt <= write_cnt + 6'd1;
            if (write_cnt == 6'd63) begin
                mpeg_ram_enabled <= 1'b1;   // 64th write
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/vmpeg_pkg.sv
`default_nettype none

package vmpeg_pkg;

    typedef logic [15:0] reg_data_t;   // One register word
    typedef logic [14:0] reg_addr_t;   // Word address, bus address bits 15:1
    typedef logic [31:0] dclk_t;       // 45 kHz decoder clock
    typedef logic [3:0]  stream_t;

    // One acknowledged bus access, valid for a single cycle
    typedef struct packed {
        logic      rd;
        logic      wr;
        reg_addr_t addr;
        reg_data_t data;
    } bus_cmd_t;

    typedef struct packed {
        logic erdv;
        logic erdd;
        logic vcup;
        logic pai;    // Pause
        logic vsync;
        logic eii;    // End of ISO stream
        logic esi;    // End of sequence
        logic tim;    // Periodic timer
        logic dcl;
        logic ovf;
        logic ndat;   // Buffer underflow
        logic rfb;
        logic eod;    // Last picture shown
        logic pic;
        logic gop;
        logic seq;
    } fmv_flags_t;

    typedef struct packed {
        logic decoding_started;
        logic frame_decoded;
        logic underflow;
        logic program_end;
    } fma_events_t;

    typedef struct packed {
        logic seq_header;
        logic gop;
        logic picture;
        logic last_picture;
        logic program_end;
        logic seq_end;
        logic underflow;
    } fmv_events_t;

    // FMA unit
    localparam reg_addr_t ADDR_FMA_CMD    = 15'h1800;
    localparam reg_addr_t ADDR_FMA_STAT   = 15'h1801;
    localparam reg_addr_t ADDR_FMA_STRM   = 15'h1804;
    localparam reg_addr_t ADDR_FMA_IVEC   = 15'h1806;
    localparam reg_addr_t ADDR_DCLKH      = 15'h1808;
    localparam reg_addr_t ADDR_DCLKL      = 15'h1809;
    localparam reg_addr_t ADDR_FMA_ISR    = 15'h180D;
    localparam reg_addr_t ADDR_FMA_IER    = 15'h180E;
    // FMV unit
    localparam reg_addr_t ADDR_FMV_IER    = 15'h2030;
    localparam reg_addr_t ADDR_FMV_ISR    = 15'h2031;
    localparam reg_addr_t ADDR_FMV_TCNT   = 15'h2032;
    localparam reg_addr_t ADDR_FMV_TRLD   = 15'h2057;
    localparam reg_addr_t ADDR_FMV_SYSCMD = 15'h2060;
    localparam reg_addr_t ADDR_FMV_STRM   = 15'h2062;
    localparam reg_addr_t ADDR_FMV_IVEC   = 15'h206E;

    // FMA status and interrupt bits
    localparam int FMA_EOI  = 0;
    localparam int FMA_UPD  = 2;
    localparam int FMA_UNF  = 3;
    localparam int FMA_DEC  = 4;
    localparam int FMA_POLL = 8;
    localparam int CMD_DMA  = 15;

    // FMV SYSCMD bits
    localparam int SYS_PLAY    = 3;
    localparam int SYS_PAUSE   = 4;
    localparam int SYS_CLEAR   = 8;
    localparam int SYS_DEC_ON  = 12;
    localparam int SYS_DEC_OFF = 13;
    localparam int SYS_DMA     = 15;

    localparam reg_data_t DEFAULT_TCNT = 16'd55;   // About 10 ms
    localparam int DEFAULT_DCLK_DIVIDER = 667;     // 30 MHz down to 45 kHz

endpackage

`default_nettype wire
